// ==== common/hazard_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface hazard_if ();

    // memory ops sitting in EX and MEM
    logic ex_is_load;
    logic ex_is_save;
    logic mem_is_load;
    logic mem_is_save;
    // EX destination matches an ID source
    logic rs_id_ex_hit;

    modport trk (
        output ex_is_load, ex_is_save, mem_is_load, mem_is_save, rs_id_ex_hit
    );

    modport ctl (
        input ex_is_load, ex_is_save, mem_is_load, mem_is_save, rs_id_ex_hit
    );

endinterface

`default_nettype wire

// ==== common/hazard_pkg.sv ====
`default_nettype none

package hazard_pkg;

    // datapath and register index widths
    localparam int XLEN  = 64;
    localparam int REG_W = 5;

    // major opcodes that need a data memory access
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // fetch start address and sequential step
    localparam logic [XLEN-1:0] PC_RESET = 64'h0000_0000_8000_0000;
    localparam logic [XLEN-1:0] PC_STEP  = 64'd4;

    // one instruction word, seen as I-type or S-type
    typedef union packed {
        struct packed {
            logic [11:0]      imm;
            logic [REG_W-1:0] rs1;
            logic [2:0]       funct3;
            logic [REG_W-1:0] rd;
            logic [6:0]       opcode;
        } i_view;
        struct packed {
            logic [6:0]       imm_hi;
            logic [REG_W-1:0] rs2;
            logic [REG_W-1:0] rs1;
            logic [2:0]       funct3;
            logic [4:0]       imm_lo;
            logic [6:0]       opcode;
        } s_view;
    } inst_u;

endpackage

`default_nettype wire

// ==== common/pipe_ctrl_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface pipe_ctrl_if ();

    // per-stage stall and flush enables
    logic pc_stall;
    logic pc_flush;
    logic if_id_stall;
    logic if_id_flush;
    logic id_ex_stall;
    logic id_ex_flush;
    logic ex_mem_stall;
    logic ex_mem_flush;
    logic mem_wb_stall;
    logic mem_wb_flush;

    modport ctl (
        output pc_stall, pc_flush,
        output if_id_stall, if_id_flush,
        output id_ex_stall, id_ex_flush,
        output ex_mem_stall, ex_mem_flush,
        output mem_wb_stall, mem_wb_flush
    );

    // slot tracker follows ID/EX onwards
    modport trk (
        input id_ex_stall, id_ex_flush,
        input ex_mem_stall, ex_mem_flush,
        input mem_wb_stall, mem_wb_flush
    );

    modport pc (
        input pc_stall, pc_flush
    );

endinterface

`default_nettype wire

// ==== common/stage_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface stage_if
    import hazard_pkg::*;
();

    // decoded info of the word in IF/ID
    logic             id_valid;
    logic             id_is_load;
    logic             id_is_save;
    // register numbers, zero when not meaningful
    logic [REG_W-1:0] id_rd;
    logic [REG_W-1:0] id_rs1;
    logic [REG_W-1:0] id_rs2;

    modport dec (
        output id_valid, id_is_load, id_is_save,
        output id_rd, id_rs1, id_rs2
    );

    modport trk (
        input id_valid, id_is_load, id_is_save,
        input id_rd, id_rs1, id_rs2
    );

endinterface

`default_nettype wire

// ==== filelist.f ====
common/hazard_pkg.sv
common/stage_if.sv
common/hazard_if.sv
common/pipe_ctrl_if.sv
rtl/inst_decode.sv
rtl/pipe_track.sv
hazard_ctrl/hazard_ctrl.sv
rtl/pc_reg.sv
rtl/hazard_top.sv
tests/tb_clkgen.sv
tests/tb_hazard_top.sv

// ==== hazard_ctrl/hazard_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module hazard_ctrl
    import hazard_pkg::*;
(
    input  logic            jump_en_i,
    input  logic [XLEN-1:0] jump_addr_i,
    input  logic            axi_busy_i,
    input  logic            axi_busy_end_i,
    hazard_if.ctl           hz,
    pipe_ctrl_if.ctl        ctl,
    output logic            jump_en_o,
    output logic [XLEN-1:0] jump_addr_o
);

    logic load_inst;
    logic save_inst;
    logic busy_hold;

    // redirect goes straight on to the PC
    assign jump_en_o   = jump_en_i;
    assign jump_addr_o = jump_addr_i;

    assign load_inst = hz.ex_is_load | hz.mem_is_load;
    assign save_inst = hz.ex_is_save | hz.mem_is_save;
    // busy releases in the busy_end cycle
    assign busy_hold = axi_busy_i & ~axi_busy_end_i;

    // flush chain, highest priority first
    always_comb begin
        ctl.pc_flush     = 1'b0;
        ctl.if_id_flush  = 1'b0;
        ctl.id_ex_flush  = 1'b0;
        ctl.ex_mem_flush = 1'b0;
        ctl.mem_wb_flush = 1'b0;
        if (jump_en_i) begin
            ctl.if_id_flush = 1'b1;
            ctl.id_ex_flush = 1'b1;
        end else if (axi_busy_i) begin
            ctl.id_ex_flush = busy_hold;
        end else if (load_inst) begin
            // bubbles into EX for as long as the load is in flight
            ctl.id_ex_flush = 1'b1;
        end else if (save_inst) begin
            ctl.id_ex_flush = 1'b1;
        end else if (hz.rs_id_ex_hit) begin
            ctl.id_ex_flush = 1'b1;
        end
    end

    // stall chain, jump plays no part here
    always_comb begin
        ctl.pc_stall     = 1'b0;
        ctl.if_id_stall  = 1'b0;
        ctl.id_ex_stall  = 1'b0;
        ctl.ex_mem_stall = 1'b0;
        ctl.mem_wb_stall = 1'b0;
        if (axi_busy_i) begin
            ctl.pc_stall     = busy_hold;
            ctl.if_id_stall  = busy_hold;
            ctl.ex_mem_stall = busy_hold;
        end else if (load_inst) begin
            ctl.pc_stall     = 1'b1;
            ctl.if_id_stall  = 1'b1;
            ctl.ex_mem_stall = hz.mem_is_load;
        end else if (save_inst) begin
            ctl.pc_stall     = 1'b1;
            ctl.if_id_stall  = 1'b1;
            ctl.ex_mem_stall = hz.mem_is_save;
        end else if (hz.rs_id_ex_hit) begin
            ctl.pc_stall    = 1'b1;
            ctl.if_id_stall = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hazard_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module hazard_top
    import hazard_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [31:0]     inst_i,
    input  logic            inst_valid_i,
    input  logic            jump_en_i,
    input  logic [XLEN-1:0] jump_addr_i,
    input  logic            axi_busy_i,
    input  logic            axi_busy_end_i,
    output logic [XLEN-1:0] pc_o,
    output logic            if_id_stall_o,
    output logic            if_id_flush_o,
    output logic            id_ex_flush_o,
    output logic            ex_mem_stall_o
);

    // jump request after the control block
    logic            jump_en;
    logic [XLEN-1:0] jump_addr;

    stage_if     st_bus ();
    hazard_if    hz_bus ();
    pipe_ctrl_if ctl_bus ();

    inst_decode u_decode (
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .st           (st_bus.dec)
    );

    pipe_track u_track (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .axi_busy_end_i (axi_busy_end_i),
        .st             (st_bus.trk),
        .hz             (hz_bus.trk),
        .pc_ctl         (ctl_bus.trk)
    );

    hazard_ctrl u_ctrl (
        .jump_en_i      (jump_en_i),
        .jump_addr_i    (jump_addr_i),
        .axi_busy_i     (axi_busy_i),
        .axi_busy_end_i (axi_busy_end_i),
        .hz             (hz_bus.ctl),
        .ctl            (ctl_bus.ctl),
        .jump_en_o      (jump_en),
        .jump_addr_o    (jump_addr)
    );

    pc_reg u_pc (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .jump_en_i   (jump_en),
        .jump_addr_i (jump_addr),
        .ctl         (ctl_bus.pc),
        .pc_o        (pc_o)
    );

    // enables used by the outside fetch unit and memory stage
    assign if_id_stall_o  = ctl_bus.if_id_stall;
    assign if_id_flush_o  = ctl_bus.if_id_flush;
    assign id_ex_flush_o  = ctl_bus.id_ex_flush;
    assign ex_mem_stall_o = ctl_bus.ex_mem_stall;

endmodule

`default_nettype wire

// ==== rtl/inst_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_decode
    import hazard_pkg::*;
(
    input  inst_u       inst_i,
    input  logic        inst_valid_i,
    stage_if.dec        st
);

    logic [6:0] opcode;
    logic       is_load;
    logic       is_save;

    // opcode lies at the same bits in both views
    assign opcode  = inst_i.i_view.opcode;
    assign is_load = (opcode == OPC_LOAD);
    assign is_save = (opcode == OPC_STORE);

    assign st.id_valid   = inst_valid_i;
    assign st.id_is_load = inst_valid_i & is_load;
    assign st.id_is_save = inst_valid_i & is_save;

    // a store writes no register, its rd bits are imm_lo
    always_comb begin
        if (inst_valid_i && !is_save) begin
            st.id_rd = inst_i.i_view.rd;
        end else begin
            st.id_rd = '0;
        end
    end

    // rs1 has the same place in I and S forms
    always_comb begin
        if (inst_valid_i) begin
            st.id_rs1 = inst_i.i_view.rs1;
        end else begin
            st.id_rs1 = '0;
        end
    end

    // loads carry immediate bits where rs2 would be
    always_comb begin
        if (inst_valid_i && !is_load) begin
            st.id_rs2 = inst_i.s_view.rs2;
        end else begin
            st.id_rs2 = '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pc_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_reg
    import hazard_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            jump_en_i,
    input  logic [XLEN-1:0] jump_addr_i,
    pipe_ctrl_if.pc         ctl,
    output logic [XLEN-1:0] pc_o
);

    logic hold;

    // a PC flush only keeps the current fetch address
    assign hold = ctl.pc_stall | ctl.pc_flush;

    // jump wins over a stall
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_o <= PC_RESET;
        end else if (jump_en_i) begin
            pc_o <= jump_addr_i;
        end else if (!hold) begin
            pc_o <= pc_o + PC_STEP;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pipe_track.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_track
    import hazard_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      axi_busy_end_i,
    stage_if.trk      st,
    hazard_if.trk     hz,
    pipe_ctrl_if.trk  pc_ctl
);

    // EX slot
    logic             ex_valid;
    logic             ex_load;
    logic             ex_save;
    logic [REG_W-1:0] ex_rd;
    // MEM slot
    logic             mem_valid;
    logic             mem_load;
    logic             mem_save;
    // memory access waiting on the bus
    logic             mem_pending;
    logic             mem_retire;

    assign mem_pending = mem_valid & (mem_load | mem_save);
    // leaves MEM once the bus is done and WB can take it
    assign mem_retire  = mem_pending
                       & ((axi_busy_end_i & ~pc_ctl.mem_wb_stall) | pc_ctl.mem_wb_flush);

    // ID/EX, flush inserts a bubble
    always_ff @(posedge clk) begin
        if (!rst_n_i || pc_ctl.id_ex_flush) begin
            ex_valid <= 1'b0;
            ex_load  <= 1'b0;
            ex_save  <= 1'b0;
        end else if (!pc_ctl.id_ex_stall) begin
            ex_valid <= st.id_valid;
            ex_load  <= st.id_is_load;
            ex_save  <= st.id_is_save;
        end
    end

    // rd only matters while ex_valid is set
    always_ff @(posedge clk) begin
        if (!pc_ctl.id_ex_stall) begin
            ex_rd <= st.id_rd;
        end
    end

    // EX/MEM, pending access holds until busy_end
    always_ff @(posedge clk) begin
        if (!rst_n_i || pc_ctl.ex_mem_flush || mem_retire) begin
            mem_valid <= 1'b0;
            mem_load  <= 1'b0;
            mem_save  <= 1'b0;
        end else if (!mem_pending && !pc_ctl.ex_mem_stall) begin
            mem_valid <= ex_valid;
            mem_load  <= ex_load;
            mem_save  <= ex_save;
        end
    end

    assign hz.ex_is_load  = ex_load;
    assign hz.ex_is_save  = ex_save;
    assign hz.mem_is_load = mem_load;
    assign hz.mem_is_save = mem_save;

    // x0 never forms a dependency
    assign hz.rs_id_ex_hit = ex_valid && (ex_rd != '0)
                          && ((ex_rd == st.id_rs1) || (ex_rd == st.id_rs2));

endmodule

`default_nettype wire

// ==== tests/tb_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    // 40 ns period
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // reset low over the first two rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/tb_hazard_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_hazard_top
    import hazard_pkg::*;
();

    logic            clk;
    logic            rst_n;
    inst_u           inst;
    logic            inst_valid;
    logic            jump_en;
    logic [XLEN-1:0] jump_addr;
    logic            axi_busy;
    logic            axi_busy_end;
    logic [XLEN-1:0] pc;
    logic            if_id_stall;
    logic            if_id_flush;
    logic            id_ex_flush;
    logic            ex_mem_stall;
    // enable bundle in if_id_stall, if_id_flush, id_ex_flush, ex_mem_stall order
    logic [3:0]      en_act;
    // fetch address expected after the latest edge
    logic [XLEN-1:0] exp_pc;
    int              cycle_cnt = 0;

    tb_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    hazard_top dut_i (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .inst_i         (inst),
        .inst_valid_i   (inst_valid),
        .jump_en_i      (jump_en),
        .jump_addr_i    (jump_addr),
        .axi_busy_i     (axi_busy),
        .axi_busy_end_i (axi_busy_end),
        .pc_o           (pc),
        .if_id_stall_o  (if_id_stall),
        .if_id_flush_o  (if_id_flush),
        .id_ex_flush_o  (id_ex_flush),
        .ex_mem_stall_o (ex_mem_stall)
    );

    assign en_act = {if_id_stall, if_id_flush, id_ex_flush, ex_mem_stall};

    // cycle ceiling for the whole run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= 400) begin
            $display("timeout, the tests did not finish within 400 cycles");
            $display("Something failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_pc(input string name, input logic [XLEN-1:0] exp_val,
                            input logic [XLEN-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("[ERROR] %s: pc expected %h, actual %h", name, exp_val, act_val);
            $display("Something failed");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic check_en(input string name, input logic [3:0] exp_val,
                            input logic [3:0] act_val);
        if (act_val !== exp_val) begin
            $display("[ERROR] %s: enables expected %b, actual %b", name, exp_val, act_val);
            $display("Something failed");
            $fatal(1, "enable mismatch");
        end
    endtask

    // nonzero register number
    function automatic logic [REG_W-1:0] rand_reg();
        rand_reg = REG_W'(($urandom % 31) + 1);
    endfunction

    // R-type fields line up with the S view
    function automatic inst_u alu_word(input logic [REG_W-1:0] rd,
                                       input logic [REG_W-1:0] rs1,
                                       input logic [REG_W-1:0] rs2);
        inst_u w;
        w = '0;
        w.s_view.opcode = 7'b0110011;
        w.s_view.imm_lo = rd;
        w.s_view.rs1    = rs1;
        w.s_view.rs2    = rs2;
        return w;
    endfunction

    function automatic inst_u load_word();
        inst_u w;
        w.i_view.imm    = 12'($urandom);
        w.i_view.rs1    = rand_reg();
        w.i_view.funct3 = 3'b011;
        w.i_view.rd     = rand_reg();
        w.i_view.opcode = OPC_LOAD;
        return w;
    endfunction

    function automatic inst_u store_word();
        inst_u w;
        w.s_view.imm_hi = 7'($urandom);
        w.s_view.rs2    = rand_reg();
        w.s_view.rs1    = rand_reg();
        w.s_view.funct3 = 3'b011;
        w.s_view.imm_lo = 5'($urandom);
        w.s_view.opcode = OPC_STORE;
        return w;
    endfunction

    // advance one rising edge and step the expected pc unless stalled
    task automatic tick(input logic step);
        @(posedge clk);
        if (step) begin
            exp_pc = exp_pc + PC_STEP;
        end
    endtask

    // outputs are settled at the falling edge
    task automatic look(input string name, input logic [3:0] exp_en);
        @(negedge clk);
        check_pc(name, exp_pc, pc);
        check_en(name, exp_en, en_act);
    endtask

    task automatic test_reset_fetch();
        int i;
        wait (rst_n === 1'b1);
        exp_pc = PC_RESET;
        look("reset_fetch", 4'b0000);
        // sources all x0 so no dependency arises
        for (i = 0; i < 6; i++) begin
            tick(1'b1);
            inst       <= alu_word(rand_reg(), '0, '0);
            inst_valid <= 1'b1;
            look("reset_fetch", 4'b0000);
        end
    endtask

    task automatic test_jump();
        logic [XLEN-1:0] target;
        target = {$urandom, $urandom} & ~64'h3;
        tick(1'b1);
        inst_valid <= 1'b0;
        jump_en    <= 1'b1;
        jump_addr  <= target;
        look("jump", 4'b0110);
        tick(1'b0);
        exp_pc = target;
        jump_en <= 1'b0;
        look("jump", 4'b0000);
    endtask

    task automatic test_busy();
        int i;
        tick(1'b1);
        axi_busy <= 1'b1;
        look("busy", 4'b1011);
        for (i = 0; i < 2; i++) begin
            tick(1'b0);
            look("busy", 4'b1011);
        end
        // busy_end releases everything in its own cycle
        tick(1'b0);
        axi_busy_end <= 1'b1;
        look("busy", 4'b0000);
        tick(1'b1);
        axi_busy     <= 1'b0;
        axi_busy_end <= 1'b0;
        look("busy", 4'b0000);
    endtask

    // memory op moves through ID and EX and then waits in MEM for the bus
    task automatic run_mem_access(input string name, input inst_u word);
        tick(1'b1);
        inst       <= word;
        inst_valid <= 1'b1;
        look(name, 4'b0000);
        tick(1'b1);
        inst_valid <= 1'b0;
        look(name, 4'b1010);
        tick(1'b0);
        look(name, 4'b1011);
        tick(1'b0);
        look(name, 4'b1011);
        tick(1'b0);
        axi_busy <= 1'b1;
        look(name, 4'b1011);
        tick(1'b0);
        axi_busy_end <= 1'b1;
        look(name, 4'b0000);
        // slot retired and fetch resumes
        tick(1'b1);
        axi_busy     <= 1'b0;
        axi_busy_end <= 1'b0;
        look(name, 4'b0000);
        tick(1'b1);
        look(name, 4'b0000);
    endtask

    task automatic test_load();
        run_mem_access("load", load_word());
    endtask

    task automatic test_store();
        run_mem_access("store", store_word());
    endtask

    task automatic test_dep_pair();
        logic [REG_W-1:0] r;
        int               k;
        // consumer reads the producer's rd through rs1 first and then through rs2
        for (k = 0; k < 2; k++) begin
            r = rand_reg();
            tick(1'b1);
            inst       <= alu_word(r, '0, '0);
            inst_valid <= 1'b1;
            look("dep_pair", 4'b0000);
            tick(1'b1);
            if (k == 0) begin
                inst <= alu_word('0, r, '0);
            end else begin
                inst <= alu_word('0, '0, r);
            end
            look("dep_pair", 4'b1010);
            // IF/ID held the consumer while EX became a bubble
            tick(1'b0);
            look("dep_pair", 4'b0000);
        end
        tick(1'b1);
        inst_valid <= 1'b0;
        look("dep_pair", 4'b0000);
    endtask

    initial begin
        void'($urandom(37650));
        inst         = '0;
        inst_valid   = 1'b0;
        jump_en      = 1'b0;
        jump_addr    = '0;
        axi_busy     = 1'b0;
        axi_busy_end = 1'b0;
        exp_pc       = PC_RESET;
        test_reset_fetch();
        test_jump();
        test_busy();
        test_load();
        test_store();
        test_dep_pair();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
